//--- bench/clockGen.sv
// Free-running 100 ns clock; reset is held low for the first two rising edges only
`default_nettype none
`timescale 1ns/1ps

module clockGen
(
	output logic clk,
	output logic rstN
);

	// Half period of 50 ns gives the 100 ns cycle
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset is released on a falling edge so it never races the rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/instrDecoder_props.sv
// Bound into every instrDecoder; checks the Wishbone ack pulse and the memory class flags
`default_nettype none
`timescale 1ns/1ps

module instrDecoder_props
(
	input logic clk,
	input logic rstN,
	input logic ack,
	input logic load,
	input logic store
);

	// ======================================================================
	// Wishbone handshake
	// ======================================================================

	// An ack is a single-cycle pulse, a held strobe must wait a cycle
	ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else $error("ack stayed high for two cycles");

	// The asynchronous reset keeps ack low
	ackLowInReset: assert property (@(posedge clk) !rstN |-> !ack)
		else $error("ack was high while reset was asserted");

	// ======================================================================
	// Decode flags
	// ======================================================================

	// One opcode cannot be a load and a store at once
	loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN) !(load && store))
		else $error("load and store were decoded together");

endmodule

// Attaches to the single decoder instance of the testbench
bind instrDecoder instrDecoder_props propsI
(
	.clk(clk),
	.rstN(rstN),
	.ack(ack),
	.load(load),
	.store(store)
);

`default_nettype wire

//--- bench/instrDecoder_tb.sv
// Self-checking testbench; assumes one cycle of ack latency and opcodes 0 to 15 assigned
`default_nettype none
`timescale 1ns/1ps

`include "qupls_consts.svh"

module instrDecoder_tb;

	localparam logic [1:0] AdrInstr = 2'(`QUPLS_ADR_INSTR);
	localparam logic [1:0] AdrCtrl = 2'(`QUPLS_ADR_CTRL);
	localparam logic [1:0] AdrImm = 2'(`QUPLS_ADR_IMM);
	localparam int RandomWords = 300;
	localparam int ImmWords = 20;
	// Reset reads, random words, opcode sweep, negative immediates, ignored writes, burst
	localparam int Accesses = 3 + RandomWords * 4 + 31 * 4 + ImmWords * 4 + 16 + 10;
	localparam longint TimeoutNs = (longint'(Accesses) * 10 + 200) * 100;

	logic clk;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [`QUPLS_XLEN-1:0] datI;
	logic [`QUPLS_XLEN-1:0] datO;
	logic ack;
	logic [31:0] rngState = 32'hc303_e48a;
	int errors = 0;
	int checks = 0;
	int testErrors = 0;
	int testChecks = 0;

	clockGen clkI (.clk(clk), .rstN(rstN));

	instrDecoder dut_i
	(
		.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datI(datI), .datO(datO), .ack(ack)
	);

	// ======================================================================
	// Reference model of the decode rules
	// ======================================================================

	function automatic logic [31:0] modelCtrl(input logic [31:0] w);
		logic [6:0] opc;
		logic isAlu;
		logic isLd;
		logic isSt;
		logic isBr;
		logic isCall;
		logic immFmt;
		logic bad;
		logic [5:0] rs2;
		opc = w[6:0];
		// R2 counts only with a defined func, everything from ADDI to JSR counts
		isAlu = (opc == 7'd1 && w[31:25] <= 7'd11) || (opc >= 7'd2 && opc <= 7'd12);
		isLd = (opc == 7'd14);
		isSt = (opc == 7'd15);
		isBr = (opc == 7'd11) || (opc == 7'd12) || (opc == 7'd13);
		isCall = (opc == 7'd11) || (opc == 7'd12);
		immFmt = (opc != 7'd1);
		rs2 = immFmt ? 6'd0 : w[24:19];
		bad = !(isAlu || isLd || isSt || isBr) && (opc != 7'd0);
		return {isAlu, isLd, isSt, isBr, isCall, immFmt, bad, w[12:7], w[18:13], rs2, 7'd0};
	endfunction

	// Sign-extended 13-bit immediate of the register-immediate format
	function automatic logic [31:0] modelImm(input logic [31:0] w);
		return (w[6:0] != 7'd1) ? {{19{w[31]}}, w[31:19]} : 32'd0;
	endfunction

	// Expected read data for one word address
	function automatic logic [31:0] expectRead(input logic [31:0] w, input logic [1:0] a);
		case (a)
			AdrInstr: return w;
			AdrCtrl: return modelCtrl(w);
			AdrImm: return modelImm(w);
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Half of the words get one of the 16 assigned opcodes, the rest keep a raw 7-bit code
	task automatic nextWord(output logic [31:0] w);
		rngState = xorshift(rngState);
		w = rngState;
		rngState = xorshift(rngState);
		if (rngState[0])
			w[6:0] = {3'b000, rngState[4:1]};
	endtask

	// ======================================================================
	// Bus and checking tasks
	// ======================================================================

	// Starts at a falling edge and returns at the falling edge where ack is seen
	task automatic access(input logic w, input logic [1:0] a, input logic [31:0] d,
		input logic hold, output logic [31:0] q);
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		adr = a;
		datI = d;
		do @(negedge clk); while (!ack);
		q = datO;
		// A held strobe lets the next access start at this same edge
		if (!hold)
		begin
			cyc = 1'b0;
			stb = 1'b0;
			we = 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		testChecks++;
		if (actual !== expected)
		begin
			errors++;
			testErrors++;
			$display("Error in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic endTest(input string name);
		$display("Test %s: %0d checks, %0d errors", name, testChecks, testErrors);
		testChecks = 0;
		testErrors = 0;
	endtask

	// Writes one word and reads back the word, the control word and the immediate
	task automatic checkWord(input string name, input logic [31:0] w,
		output logic [31:0] ctrl, output logic [31:0] imm);
		logic [31:0] q;
		access(1'b1, AdrInstr, w, 1'b0, q);
		access(1'b0, AdrInstr, 32'd0, 1'b0, q);
		check(name, w, q);
		access(1'b0, AdrCtrl, 32'd0, 1'b0, ctrl);
		check(name, modelCtrl(w), ctrl);
		access(1'b0, AdrImm, 32'd0, 1'b0, imm);
		check(name, modelImm(w), imm);
	endtask

	// Ends a stuck run; the limit allows ten cycles per bus access
	initial
	begin
		#(TimeoutNs);
		$display("Timeout: the bus accesses did not complete in the allowed time");
		$display("TB FAILED");
		$finish;
	end

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial
	begin
		logic [31:0] word;
		logic [31:0] junk;
		logic [31:0] ctrl;
		logic [31:0] imm;
		logic [31:0] q;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		datI = 32'd0;
		@(posedge rstN);

		// The register resets to zero, which decodes as SYS
		for (int a = 0; a < 3; a++)
		begin
			access(1'b0, 2'(a), 32'd0, 1'b0, q);
			check("reset", expectRead(32'd0, 2'(a)), q);
		end
		endTest("reset");

		for (int i = 0; i < RandomWords; i++)
		begin
			nextWord(word);
			checkWord("random", word, ctrl, imm);
		end
		endTest("random");

		// Every assigned opcode once, R2 swept over defined and undefined funcs
		for (int opc = 0; opc < 16; opc++)
		begin
			for (int fn = 0; fn < ((opc == 1) ? 16 : 1); fn++)
			begin
				nextWord(word);
				word[6:0] = 7'(opc);
				if (opc == 1)
					word[31:25] = 7'(fn);
				checkWord("opcodes", word, ctrl, imm);
				if (opc == 1)
					check("opcodes", {31'd0, fn > 11}, {31'd0, ctrl[25]});
			end
		end
		endTest("opcodes");

		// Immediate formats with the sign bit set read as negative and carry no rs2
		for (int i = 0; i < ImmWords; i++)
		begin
			nextWord(word);
			word[6:0] = 7'(2 + word[15:7] % 14);
			word[31] = 1'b1;
			checkWord("negImm", word, ctrl, imm);
			check("negImm", 32'd1, {31'd0, imm[31]});
			check("negImm", 32'd0, {26'd0, ctrl[12:7]});
		end
		endTest("negImm");

		// Writes outside the instruction address change nothing
		nextWord(word);
		checkWord("ignoredWrite", word, ctrl, imm);
		for (int a = 1; a < 4; a++)
		begin
			nextWord(junk);
			access(1'b1, 2'(a), junk, 1'b0, q);
			for (int r = 0; r < 3; r++)
			begin
				access(1'b0, 2'(r), 32'd0, 1'b0, q);
				check("ignoredWrite", expectRead(word, 2'(r)), q);
			end
		end
		endTest("ignoredWrite");

		// Six reads with the strobe held until the last one
		nextWord(word);
		checkWord("burst", word, ctrl, imm);
		for (int i = 0; i < 6; i++)
		begin
			access(1'b0, 2'(i % 3), 32'd0, i < 5, q);
			check("burst", expectRead(word, 2'(i % 3)), q);
		end
		endTest("burst");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/quplsPkg.sv
source/decodeAlu.sv
source/decodeMem.sv
source/decodeBranch.sv
source/decodeRegs.sv
source/wbDecodePort.sv
source/instrDecoder.sv
bench/clockGen.sv
bench/instrDecoder_props.sv
bench/instrDecoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the log decides the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module instrDecoder_tb -f project.f --Mdir build -o simv

./build/simv | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi

//--- source/decodeAlu.sv
// Combinational; an R2 word is an ALU op only when its func code is defined
`default_nettype none
`timescale 1ns/1ps

module decodeAlu
(
	input  quplsPkg::instruction_t instr,
	output logic alu
);

	// Classifies one instruction word for the ALU class
	function automatic logic fnIsAlu(input quplsPkg::instruction_t ir);
		logic result;
		result = 1'b0;
		case (ir.r2.opcode)
			// SYS traps to the system and never uses the ALU
			quplsPkg::OP_SYS:
				result = 1'b0;
			// Register-register ops depend on the function field
			quplsPkg::OP_R2:
				case (ir.r2.func)
					quplsPkg::FN_ADD, quplsPkg::FN_SUB, quplsPkg::FN_CMP,
					quplsPkg::FN_MUL, quplsPkg::FN_DIV:
						result = 1'b1;
					quplsPkg::FN_AND, quplsPkg::FN_OR, quplsPkg::FN_EOR,
					quplsPkg::FN_NAND, quplsPkg::FN_NOR:
						result = 1'b1;
					quplsPkg::FN_SLT, quplsPkg::FN_SLTU:
						result = 1'b1;
					default:
						result = 1'b0;
				endcase
			// Immediate arithmetic and logic
			quplsPkg::OP_ADDI, quplsPkg::OP_CMPI, quplsPkg::OP_ANDI,
			quplsPkg::OP_ORI, quplsPkg::OP_EORI, quplsPkg::OP_SHIFT:
				result = 1'b1;
			// Moves and the no-op still pass through an ALU slot
			quplsPkg::OP_LDI, quplsPkg::OP_MOV, quplsPkg::OP_NOP:
				result = 1'b1;
			// The link register write of a call is done by the ALU
			quplsPkg::OP_BSR, quplsPkg::OP_JSR:
				result = 1'b1;
			default:
				result = 1'b0;
		endcase
		return result;
	endfunction

	assign alu = fnIsAlu(instr);

endmodule

`default_nettype wire

//--- source/decodeBranch.sv
// Combinational; calls are flagged as branches too, their link write goes to the ALU
`default_nettype none
`timescale 1ns/1ps

module decodeBranch
(
	input  quplsPkg::instruction_t instr,
	output logic branch,
	output logic call
);

	// Flow-control opcodes seen by this block
	logic isBcc;
	logic isLink;

	// Conditional branch without a link
	assign isBcc = (instr.r2.opcode == quplsPkg::OP_BCC);

	// Branch to subroutine and jump to subroutine both write a link register
	assign isLink = (instr.r2.opcode == quplsPkg::OP_BSR) ||
		(instr.r2.opcode == quplsPkg::OP_JSR);

	// Every flow change redirects fetch
	assign branch = isBcc | isLink;
	assign call = isLink;

endmodule

`default_nettype wire

//--- source/decodeMem.sv
// Combinational; only plain LOAD and STORE opcodes are recognised
`default_nettype none
`timescale 1ns/1ps

module decodeMem
(
	input  quplsPkg::instruction_t instr,
	output logic load,
	output logic store
);

	// ======================================================================
	// Memory class
	// ======================================================================

	// Opcode field sits in the same place in both formats
	quplsPkg::opcode_t opc;

	assign opc = instr.r2.opcode;

	// Loads and stores are mutually exclusive by opcode
	always_comb
	begin
		load = 1'b0;
		store = 1'b0;
		case (opc)
			quplsPkg::OP_LOAD:
				load = 1'b1;
			quplsPkg::OP_STORE:
				store = 1'b1;
			default:
			begin
				load = 1'b0;
				store = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/decodeRegs.sv
// Combinational; the immediate is 13 bits sign-extended, rs2 exists only for R2
`default_nettype none
`timescale 1ns/1ps

`include "qupls_consts.svh"

module decodeRegs
(
	input  quplsPkg::instruction_t instr,
	output logic hasImm,
	output logic [`QUPLS_REG_W-1:0] rd,
	output logic [`QUPLS_REG_W-1:0] rs1,
	output logic [`QUPLS_REG_W-1:0] rs2,
	output logic [`QUPLS_XLEN-1:0] imm
);

	// ======================================================================
	// Register and immediate fields
	// ======================================================================

	// Every opcode except R2 carries an immediate
	assign hasImm = (instr.r2.opcode != quplsPkg::OP_R2);

	// The format picks which view of the union is read
	always_comb
	begin
		if (!hasImm)
		begin
			// Register-register form has a second source and no immediate
			rd = instr.r2.rd;
			rs1 = instr.r2.rs1;
			rs2 = instr.r2.rs2;
			imm = '0;
		end
		else
		begin
			// Immediate form, rs2 is masked so the upper bits are not mistaken for a register
			rd = instr.ri.rd;
			rs1 = instr.ri.rs1;
			rs2 = '0;
			imm = {{(`QUPLS_XLEN-`QUPLS_IMM_W){instr.ri.imm[`QUPLS_IMM_W-1]}}, instr.ri.imm};
		end
	end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
// Standalone decoder on a Wishbone classic slave port; no byte lanes and no error response
`default_nettype none
`timescale 1ns/1ps

`include "qupls_consts.svh"

module instrDecoder
(
	input  logic clk,
	input  logic rstN,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [1:0] adr,
	input  logic [`QUPLS_XLEN-1:0] datI,
	output logic [`QUPLS_XLEN-1:0] datO,
	output logic ack
);

	// Instruction register fans out to all classifiers
	quplsPkg::instruction_t instr;
	logic alu;
	logic load;
	logic store;
	logic branch;
	logic call;
	logic hasImm;
	logic [`QUPLS_REG_W-1:0] rd;
	logic [`QUPLS_REG_W-1:0] rs1;
	logic [`QUPLS_REG_W-1:0] rs2;
	logic [`QUPLS_XLEN-1:0] imm;

	wbDecodePort portI
	(
		.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datI(datI),
		.alu(alu), .load(load), .store(store), .branch(branch), .call(call),
		.hasImm(hasImm), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.instr(instr), .datO(datO), .ack(ack)
	);

	// The four classifiers work side by side on the same word
	decodeAlu aluI (.instr(instr), .alu(alu));
	decodeMem memI (.instr(instr), .load(load), .store(store));
	decodeBranch branchI (.instr(instr), .branch(branch), .call(call));
	decodeRegs regsI
	(
		.instr(instr), .hasImm(hasImm), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
	);

endmodule

`default_nettype wire

//--- source/quplsPkg.sv
// Only the opcodes of the reduced set are listed; codes 16 to 127 are unassigned
`default_nettype none

`include "qupls_consts.svh"

package quplsPkg;

	// ======================================================================
	// Opcode and function encodings
	// ======================================================================

	// Primary opcode in the low seven bits of every instruction
	typedef enum logic [`QUPLS_OPC_W-1:0]
	{
		OP_SYS   = 7'd0,
		OP_R2    = 7'd1,
		OP_ADDI  = 7'd2,
		OP_CMPI  = 7'd3,
		OP_ANDI  = 7'd4,
		OP_ORI   = 7'd5,
		OP_EORI  = 7'd6,
		OP_SHIFT = 7'd7,
		OP_LDI   = 7'd8,
		OP_MOV   = 7'd9,
		OP_NOP   = 7'd10,
		OP_BSR   = 7'd11,
		OP_JSR   = 7'd12,
		OP_BCC   = 7'd13,
		OP_LOAD  = 7'd14,
		OP_STORE = 7'd15
	} opcode_t;

	// Function code of the register-register format, codes 12 and up are undefined
	typedef enum logic [`QUPLS_FUNC_W-1:0]
	{
		FN_ADD  = 7'd0,
		FN_SUB  = 7'd1,
		FN_CMP  = 7'd2,
		FN_MUL  = 7'd3,
		FN_DIV  = 7'd4,
		FN_AND  = 7'd5,
		FN_OR   = 7'd6,
		FN_EOR  = 7'd7,
		FN_NAND = 7'd8,
		FN_NOR  = 7'd9,
		FN_SLT  = 7'd10,
		FN_SLTU = 7'd11
	} func_t;

	// ======================================================================
	// Instruction formats
	// ======================================================================

	// Register-register view, fields listed from bit 31 down
	typedef struct packed
	{
		func_t func;
		logic [`QUPLS_REG_W-1:0] rs2;
		logic [`QUPLS_REG_W-1:0] rs1;
		logic [`QUPLS_REG_W-1:0] rd;
		opcode_t opcode;
	} r2Format_t;

	// Register-immediate view, the immediate takes the place of rs2 and func
	typedef struct packed
	{
		logic [`QUPLS_IMM_W-1:0] imm;
		logic [`QUPLS_REG_W-1:0] rs1;
		logic [`QUPLS_REG_W-1:0] rd;
		opcode_t opcode;
	} riFormat_t;

	// Both views overlay the same 32 bits
	typedef union packed
	{
		r2Format_t r2;
		riFormat_t ri;
	} instruction_t;

	// Decoded control word as read back at the control address
	typedef struct packed
	{
		logic isAlu;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isCall;
		logic hasImm;
		logic illegal;
		logic [`QUPLS_REG_W-1:0] rd;
		logic [`QUPLS_REG_W-1:0] rs1;
		logic [`QUPLS_REG_W-1:0] rs2;
		logic [6:0] pad;
	} decode_t;

endpackage

`default_nettype wire

//--- source/qupls_consts.svh
// Field widths are fixed by the instruction format; changing them breaks the union layout
`ifndef QUPLS_CONSTS_SVH
`define QUPLS_CONSTS_SVH

// ======================================================================
// Datapath and instruction field widths
// ======================================================================

// Bus width and instruction width are the same word
`define QUPLS_XLEN 32

// Instruction field widths in bits
`define QUPLS_OPC_W 7
`define QUPLS_REG_W 6
`define QUPLS_FUNC_W 7
`define QUPLS_IMM_W 13

// ======================================================================
// Word addresses on the Wishbone port
// ======================================================================
`define QUPLS_ADR_INSTR 0
`define QUPLS_ADR_CTRL 1
`define QUPLS_ADR_IMM 2

`endif

//--- source/wbDecodePort.sv
// Wishbone classic, full words only, every access acked one cycle after it is sampled
`default_nettype none
`timescale 1ns/1ps

`include "qupls_consts.svh"

module wbDecodePort
(
	input  logic clk,
	input  logic rstN,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [1:0] adr,
	input  logic [`QUPLS_XLEN-1:0] datI,
	input  logic alu,
	input  logic load,
	input  logic store,
	input  logic branch,
	input  logic call,
	input  logic hasImm,
	input  logic [`QUPLS_REG_W-1:0] rd,
	input  logic [`QUPLS_REG_W-1:0] rs1,
	input  logic [`QUPLS_REG_W-1:0] rs2,
	input  logic [`QUPLS_XLEN-1:0] imm,
	output quplsPkg::instruction_t instr,
	output logic [`QUPLS_XLEN-1:0] datO,
	output logic ack
);

	quplsPkg::decode_t ctrl;
	logic req;
	logic [`QUPLS_XLEN-1:0] rdData;

	// A request is taken only while ack is low, so a held strobe costs two cycles
	assign req = cyc & stb & ~ack;

	// Collect the classifier outputs into the control word
	always_comb
	begin
		ctrl = '0;
		ctrl.isAlu = alu;
		ctrl.isLoad = load;
		ctrl.isStore = store;
		ctrl.isBranch = branch;
		ctrl.isCall = call;
		ctrl.hasImm = hasImm;
		// Nothing claimed the word and it is not a system call
		ctrl.illegal = ~(alu | load | store | branch) &&
			(instr.r2.opcode != quplsPkg::OP_SYS);
		ctrl.rd = rd;
		ctrl.rs1 = rs1;
		ctrl.rs2 = rs2;
	end

	// Read data selected by word address
	always_comb
	begin
		case (adr)
			2'(`QUPLS_ADR_INSTR): rdData = instr;
			2'(`QUPLS_ADR_CTRL): rdData = ctrl;
			2'(`QUPLS_ADR_IMM): rdData = imm;
			default: rdData = '0;
		endcase
	end

	// ======================================================================
	// Bus registers
	// ======================================================================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ack <= 1'b0;
			datO <= '0;
			instr <= '0;
		end
		else
		begin
			ack <= req;
			if (req)
			begin
				datO <= rdData;
				// Only the instruction address is writable
				if (we && adr == 2'(`QUPLS_ADR_INSTR))
					instr <= datI;
			end
		end
	end

endmodule

`default_nettype wire
